// ==== project.f ====
common/msx_cfg_pkg.sv
common/msx_io_pkg.sv
verilog/msx_io_decode.sv
verilog/slot_select.sv
verilog/ram_mapper.sv
rtc/rtc_regs.sv
verilog/msx2_glue.sv
tests/tb_msx2_glue.sv

// ==== Bender.yml ====
package:
  name: msx2_glue

sources:
  # Packages first, then RTL leaves up to the top level
  - common/msx_cfg_pkg.sv
  - common/msx_io_pkg.sv
  - verilog/msx_io_decode.sv
  - verilog/slot_select.sv
  - verilog/ram_mapper.sv
  - rtc/rtc_regs.sv
  - verilog/msx2_glue.sv
  - target: test
    files:
      - tests/tb_msx2_glue.sv

// ==== tests/tb_msx2_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_msx2_glue;
   import msx_cfg_pkg::*;

   // The tests need roughly 800 clocks
   localparam int TIMEOUT_CLKS = 2000;

   logic        reset = 1'b0;
   logic        clk21m;
   logic        ce_10hz;
   logic [15:0] addr;
   logic  [7:0] d_from_cpu;
   logic        wr_n;
   logic        rd_n;
   logic        iorq_n;
   logic        mreq_n;
   logic        m1_n;
   logic        rfrsh_n;
   logic  [7:0] addr_map;
   logic        map_valid;
   ram_size_t   ram_size;
   wire   [7:0] d_to_cpu;
   wire         data_bus_rq;
   wire         cs0_n;
   wire         cs1_n;
   wire         cs2_n;
   wire         cs01_n;
   wire         cs12_n;
   wire   [3:0] sltsl_n;
   wire   [3:0] slt3_n;
   wire   [7:0] ram_bank;

   integer      seed = 32'h462e2159;
   int          err_cnt = 0;
   int          err_base = 0;
   int          tests_pass = 0;
   int          tests_fail = 0;
   int          hour;
   logic  [7:0] q_data;
   logic        q_rq;
   logic  [3:0] q_sltsl;
   logic  [3:0] q_slt3;
   logic  [4:0] q_cs;
   logic  [7:0] q_bank;
   logic  [7:0] wdata;
   logic  [7:0] amap;
   logic  [7:0] port;
   logic        mv;
   logic  [1:0] pg;
   logic  [1:0] slot;
   logic  [3:0] exp_n;
   logic  [3:0] rtc_exp [0:15];

   msx2_glue dut_i (.*);

   always #10 reset = ~reset;

   // No slot select while the Z80 refreshes DRAM
   assert property (@(posedge reset) disable iff (clk21m) !rfrsh_n |-> sltsl_n == 4'hF)
      else begin
         $display("ERR sltsl_n expected f got %h in refresh", $sampled(sltsl_n));
         err_cnt++;
      end

   task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp) else begin
         $display("ERR %s expected %h got %h", name, exp, act);
         err_cnt++;
      end
   endtask

   // Each size step doubles the four 16K segments of 64K
   function automatic logic [7:0] mask_for_size(input int s);
      return ~((8'd4 << s) - 8'd1);
   endfunction

   task automatic sample_outputs;
      @(negedge reset);
      q_data  = d_to_cpu;
      q_rq    = data_bus_rq;
      q_sltsl = sltsl_n;
      q_slt3  = slt3_n;
      q_cs    = {cs0_n, cs1_n, cs2_n, cs01_n, cs12_n};
      q_bank  = ram_bank;
   endtask

   // One Z80 cycle held for three clocks
   task automatic bus_cycle(input bit io, input bit wr, input bit rf,
                            input logic [15:0] a, input logic [7:0] d);
      @(posedge reset);
      addr       <= a;
      d_from_cpu <= d;
      iorq_n     <= ~io;
      mreq_n     <= io;
      wr_n       <= ~wr;
      rd_n       <= wr | ~rf;
      rfrsh_n    <= rf;
      repeat (2) @(posedge reset);
      sample_outputs();
      @(posedge reset);
      iorq_n  <= 1'b1;
      mreq_n  <= 1'b1;
      wr_n    <= 1'b1;
      rd_n    <= 1'b1;
      rfrsh_n <= 1'b1;
   endtask

   task automatic io_write(input logic [7:0] p, input logic [7:0] d);
      bus_cycle(1'b1, 1'b1, 1'b1, {8'h00, p}, d);
   endtask

   task automatic io_read(input logic [7:0] p);
      bus_cycle(1'b1, 1'b0, 1'b1, {8'h00, p}, 8'h00);
   endtask

   task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
      bus_cycle(1'b0, 1'b1, 1'b1, a, d);
   endtask

   task automatic mem_read(input logic [15:0] a);
      bus_cycle(1'b0, 1'b0, 1'b1, a, 8'h00);
   endtask

   task automatic refresh(input logic [15:0] a);
      bus_cycle(1'b0, 1'b0, 1'b0, a, 8'h00);
   endtask

   task automatic idle_at(input logic [15:0] a);
      @(posedge reset);
      addr <= a;
      sample_outputs();
   endtask

   task automatic configure(input logic [7:0] m, input logic v, input int s);
      @(posedge reset);
      addr_map  <= m;
      map_valid <= v;
      ram_size  <= ram_size_t'(s);
   endtask

   // The clock chip takes only the low nibble of each write
   task automatic rtc_write(input logic [3:0] idx, input logic [3:0] v);
      logic [7:0] r;
      r = $random(seed);
      io_write(8'hB4, {r[7:4], idx});
      io_write(8'hB5, {r[3:0], v});
   endtask

   task automatic rtc_read(input logic [3:0] idx);
      io_write(8'hB4, {4'h0, idx});
      io_read(8'hB5);
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_base) begin
         tests_pass++;
         $display("test %-26s ok", name);
      end else begin
         tests_fail++;
         $display("test %-26s FAILED with %0d errors", name, err_cnt - err_base);
      end
      err_base = err_cnt;
   endtask

   initial begin
      clk21m     = 1'b1;
      ce_10hz    = 1'b0;
      addr       = 16'h0000;
      d_from_cpu = 8'h00;
      wr_n       = 1'b1;
      rd_n       = 1'b1;
      iorq_n     = 1'b1;
      mreq_n     = 1'b1;
      m1_n       = 1'b1;
      rfrsh_n    = 1'b1;
      addr_map   = 8'h00;
      map_valid  = 1'b0;
      ram_size   = size64;
      repeat (3) @(posedge reset);
      clk21m <= 1'b0;

      for (int p = 0; p < 4; p++) begin
         pg = p;
         io_read({6'h3F, pg});
         check_val("d_to_cpu", (8'd3 - pg) | mask_for_size(0), q_data);
         idle_at({pg, 14'h0123});
         check_val("ram_bank", 8'd3 - pg, q_bank);
      end
      for (int s = 0; s < 4; s++) begin
         configure(8'h00, 1'b0, s);
         for (int p = 0; p < 4; p++) begin
            pg    = p;
            wdata = $random(seed);
            io_write({6'h3F, pg}, wdata);
            io_read({6'h3F, pg});
            check_val("d_to_cpu", wdata | mask_for_size(s), q_data);
            idle_at({pg, 14'h2A5C});
            check_val("ram_bank", wdata & ~mask_for_size(s), q_bank);
         end
      end
      end_test("mapper reset and masking");

      for (int i = 0; i < 24; i++) begin
         pg   = i[1:0];
         amap = $random(seed);
         mv   = (i % 3) != 2;
         configure(amap, mv, 3);
         mem_read({pg, 14'h1357});
         slot = mv ? amap[2*pg +: 2] : 2'd0;
         check_val("sltsl_n", {4'h0, ~(4'b0001 << slot)}, {4'h0, q_sltsl});
         check_val("cs_n", {3'b000, pg != 0, pg != 1, pg != 2, pg[1], pg == 0 || pg == 3},
                   {3'b000, q_cs});
         refresh({pg, 14'h1357});
         check_val("sltsl_n", 8'h0F, {4'h0, q_sltsl});
      end
      end_test("primary slot selection");

      configure(8'hC0, 1'b1, 3);
      wdata = $random(seed);
      mem_write(16'hFFFF, wdata);
      mem_read(16'hFFFF);
      check_val("d_to_cpu", ~wdata, q_data);
      check_val("data_bus_rq", 8'h01, {7'h00, q_rq});
      for (int i = 0; i < 8; i++) begin
         pg   = i[1:0];
         amap = $random(seed);
         if (i < 4) begin
            amap[2*pg +: 2] = 2'b11;
         end
         configure(amap, 1'b1, 3);
         mem_read({pg, 14'h0100});
         exp_n = (amap[2*pg +: 2] == 2'b11) ? ~(4'b0001 << wdata[2*pg +: 2]) : 4'hF;
         check_val("slt3_n", {4'h0, exp_n}, {4'h0, q_slt3});
      end
      end_test("subslot register");

      for (int i = 6; i < 14; i++) begin
         rtc_exp[i] = $random(seed);
         rtc_write(i, rtc_exp[i]);
      end
      rtc_write(14, 4'hA);
      rtc_write(15, 4'h5);
      for (int i = 6; i < 16; i++) begin
         rtc_read(i);
         check_val("d_to_cpu", {4'hF, (i < 14) ? rtc_exp[i] : 4'h0}, q_data);
      end
      end_test("clock chip registers");

      hour = {$random(seed)} % 24;
      rtc_write(0, 4'd8);
      rtc_write(1, 4'd5);
      rtc_write(2, 4'd9);
      rtc_write(3, 4'd5);
      rtc_write(4, hour % 10);
      rtc_write(5, hour / 10);
      repeat (20) begin
         @(posedge reset);
         ce_10hz <= 1'b1;
         @(posedge reset);
         ce_10hz <= 1'b0;
         repeat (2) @(posedge reset);
      end
      repeat (3) @(posedge reset);
      // 58 s plus two seconds rolls every field over
      hour = (hour + 1) % 24;
      for (int i = 0; i < 4; i++) begin
         rtc_exp[i] = 4'd0;
      end
      rtc_exp[4] = hour % 10;
      rtc_exp[5] = hour / 10;
      for (int i = 0; i < 6; i++) begin
         rtc_read(i);
         check_val("d_to_cpu", {4'hF, rtc_exp[i]}, q_data);
      end
      end_test("clock chip counting");

      io_read(8'h98);
      check_val("d_to_cpu", 8'hFF, q_data);
      check_val("data_bus_rq", 8'h00, {7'h00, q_rq});
      do begin
         port = $random(seed);
      end while (port[7:1] == 7'h5A || port[7:2] == 6'h3F);
      io_read(port);
      check_val("d_to_cpu", 8'hFF, q_data);
      check_val("data_bus_rq", 8'h00, {7'h00, q_rq});
      // Data changes after the strobe clock of a long write
      wdata = $random(seed);
      @(posedge reset);
      addr       <= 16'h00FD;
      d_from_cpu <= wdata;
      iorq_n     <= 1'b0;
      wr_n       <= 1'b0;
      @(posedge reset);
      d_from_cpu <= ~wdata;
      repeat (4) @(posedge reset);
      iorq_n <= 1'b1;
      wr_n   <= 1'b1;
      io_read(8'hFD);
      check_val("d_to_cpu", wdata | mask_for_size(3), q_data);
      wdata = $random(seed);
      io_write(8'hFD, wdata);
      io_read(8'hFD);
      check_val("d_to_cpu", wdata | mask_for_size(3), q_data);
      end_test("unclaimed and held cycles");

      $display("Tests passed %0d, failed %0d", tests_pass, tests_fail);
      if (err_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CLKS) @(posedge reset);
      $display("Timeout: tests did not finish within %0d clocks", TIMEOUT_CLKS);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/msx2_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx2_glue (
   input  wire                   reset,
   input  wire                   clk21m,
   input  wire                   ce_10hz,
   input  wire            [15:0] addr,
   input  wire             [7:0] d_from_cpu,
   input  wire                   wr_n,
   input  wire                   rd_n,
   input  wire                   iorq_n,
   input  wire                   mreq_n,
   input  wire                   m1_n,
   input  wire                   rfrsh_n,
   input  wire             [7:0] addr_map,
   input  wire                   map_valid,
   input  wire msx_cfg_pkg::ram_size_t ram_size,
   output logic            [7:0] d_to_cpu,
   output logic                  data_bus_rq,
   output logic                  cs0_n,
   output logic                  cs1_n,
   output logic                  cs2_n,
   output logic                  cs01_n,
   output logic                  cs12_n,
   output logic            [3:0] sltsl_n,
   output logic            [3:0] slt3_n,
   output logic            [7:0] ram_bank
);

   logic       rtc_wr;
   logic       mpr_wr;
   logic       sub_wr;
   logic       slot3_sel;
   logic [7:0] rtc_rdata;
   logic [7:0] mpr_rdata;
   logic [7:0] sub_rdata;

   msx_io_decode io_decode_i (
      .reset       (reset),
      .clk21m      (clk21m),
      .addr        (addr),
      .wr_n        (wr_n),
      .rd_n        (rd_n),
      .iorq_n      (iorq_n),
      .mreq_n      (mreq_n),
      .m1_n        (m1_n),
      .slot3_sel   (slot3_sel),
      .rtc_rdata   (rtc_rdata),
      .mpr_rdata   (mpr_rdata),
      .sub_rdata   (sub_rdata),
      .rtc_wr      (rtc_wr),
      .mpr_wr      (mpr_wr),
      .sub_wr      (sub_wr),
      .d_to_cpu    (d_to_cpu),
      .data_bus_rq (data_bus_rq)
   );

   slot_select slot_select_i (
      .reset      (reset),
      .clk21m     (clk21m),
      .addr       (addr),
      .mreq_n     (mreq_n),
      .rfrsh_n    (rfrsh_n),
      .addr_map   (addr_map),
      .map_valid  (map_valid),
      .sub_wr     (sub_wr),
      .d_from_cpu (d_from_cpu),
      .cs0_n      (cs0_n),
      .cs1_n      (cs1_n),
      .cs2_n      (cs2_n),
      .cs01_n     (cs01_n),
      .cs12_n     (cs12_n),
      .sltsl_n    (sltsl_n),
      .slt3_n     (slt3_n),
      .slot3_sel  (slot3_sel),
      .sub_rdata  (sub_rdata)
   );

   ram_mapper ram_mapper_i (
      .reset      (reset),
      .clk21m     (clk21m),
      .addr       (addr),
      .mpr_wr     (mpr_wr),
      .d_from_cpu (d_from_cpu),
      .ram_size   (ram_size),
      .ram_bank   (ram_bank),
      .mpr_rdata  (mpr_rdata)
   );

   rtc_regs rtc_regs_i (
      .reset      (reset),
      .clk21m     (clk21m),
      .ce_10hz    (ce_10hz),
      .addr       (addr),
      .rtc_wr     (rtc_wr),
      .d_from_cpu (d_from_cpu),
      .rtc_rdata  (rtc_rdata)
   );

endmodule

`default_nettype wire

// ==== rtc/rtc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtc_regs (
   input  wire        reset,
   input  wire        clk21m,
   input  wire        ce_10hz,
   input  wire [15:0] addr,
   input  wire        rtc_wr,
   input  wire  [7:0] d_from_cpu,
   output logic [7:0] rtc_rdata
);
   import msx_io_pkg::*;

   rtc_reg_t   idx;
   logic [3:0] regs [0:13];
   logic [3:0] tick_cnt;
   logic       sec_pulse;
   logic       idx_wr;
   logic       dat_wr;
   logic [3:0] rd_nib;
   logic [8:0] sec_step;
   logic [8:0] min_step;
   logic [8:0] hr_step;

   // Steps one BCD digit pair with the carry in bit 8
   function automatic logic [8:0] bcd_step(input logic [3:0] hi, input logic [3:0] lo,
                                           input logic [3:0] hi_max,
                                           input logic [3:0] lo_max);
      if (hi == hi_max && lo == lo_max) begin
         return 9'h100;
      end else if (lo >= 4'd9) begin
         return {1'b0, hi + 4'd1, 4'd0};
      end
      return {1'b0, hi, lo + 4'd1};
   endfunction

   assign idx_wr = rtc_wr & (addr[0] == PORT_RTC_BASE[0]);
   assign dat_wr = rtc_wr & (addr[0] != PORT_RTC_BASE[0]) & (idx < reg_test);

   assign sec_step = bcd_step(regs[reg_sec_hi], regs[reg_sec_lo], 4'd5, 4'd9);
   assign min_step = bcd_step(regs[reg_min_hi], regs[reg_min_lo], 4'd5, 4'd9);
   assign hr_step  = bcd_step(regs[reg_hour_hi], regs[reg_hour_lo], 4'd2, 4'd3);

   // Divide ce_10hz down to one pulse per second
   always_ff @(posedge reset or posedge clk21m) begin
      if (clk21m) begin
         tick_cnt  <= 4'd0;
         sec_pulse <= 1'b0;
      end else begin
         sec_pulse <= 1'b0;
         if (ce_10hz) begin
            if (tick_cnt == RTC_TICKS_PER_SEC - 1) begin
               tick_cnt  <= 4'd0;
               sec_pulse <= 1'b1;
            end else begin
               tick_cnt <= tick_cnt + 4'd1;
            end
         end
      end
   end

   always_ff @(posedge reset or posedge clk21m) begin
      if (clk21m) begin
         idx <= reg_sec_lo;
         for (int i = 0; i < 14; i++) begin
            regs[i] <= 4'd0;
         end
      end else begin
         if (idx_wr) begin
            idx <= rtc_reg_t'(d_from_cpu[3:0]);
         end
         if (sec_pulse) begin
            regs[reg_sec_lo] <= sec_step[3:0];
            regs[reg_sec_hi] <= sec_step[7:4];
            if (sec_step[8]) begin
               regs[reg_min_lo] <= min_step[3:0];
               regs[reg_min_hi] <= min_step[7:4];
               if (min_step[8]) begin
                  regs[reg_hour_lo] <= hr_step[3:0];
                  regs[reg_hour_hi] <= hr_step[7:4];
               end
            end
         end
         // Last assignment wins over the count
         if (dat_wr) begin
            regs[idx] <= d_from_cpu[3:0];
         end
      end
   end

   // Test and reset registers have no storage
   assign rd_nib    = (idx < reg_test) ? regs[idx] : 4'h0;
   assign rtc_rdata = {4'hF, rd_nib};

endmodule

`default_nettype wire

// ==== verilog/ram_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_mapper (
   input  wire                   reset,
   input  wire                   clk21m,
   input  wire            [15:0] addr,
   input  wire                   mpr_wr,
   input  wire             [7:0] d_from_cpu,
   input  wire msx_cfg_pkg::ram_size_t ram_size,
   output logic            [7:0] ram_bank,
   output logic            [7:0] mpr_rdata
);
   import msx_cfg_pkg::*;

   logic [7:0] seg [0:3];
   logic [7:0] ram_mask;

   always_comb begin
      ram_mask = MAPPER_MASK_512;
      case (ram_size)
         size64:  ram_mask = MAPPER_MASK_64;
         size128: ram_mask = MAPPER_MASK_128;
         size256: ram_mask = MAPPER_MASK_256;
         size512: ram_mask = MAPPER_MASK_512;
      endcase
   end

   // Port FC..FF selects the page by its low address bits
   always_ff @(posedge reset or posedge clk21m) begin
      if (clk21m) begin
         for (int i = 0; i < 4; i++) begin
            seg[i] <= MAPPER_RESET_SEG[i];
         end
      end else if (mpr_wr) begin
         seg[addr[1:0]] <= d_from_cpu & ~ram_mask;
      end
   end

   assign ram_bank = seg[addr[15:14]];

   // Missing segment bits read back as ones
   assign mpr_rdata = seg[addr[1:0]] | ram_mask;

endmodule

`default_nettype wire

// ==== verilog/slot_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_select (
   input  wire        reset,
   input  wire        clk21m,
   input  wire [15:0] addr,
   input  wire        mreq_n,
   input  wire        rfrsh_n,
   input  wire  [7:0] addr_map,
   input  wire        map_valid,
   input  wire        sub_wr,
   input  wire  [7:0] d_from_cpu,
   output logic       cs0_n,
   output logic       cs1_n,
   output logic       cs2_n,
   output logic       cs01_n,
   output logic       cs12_n,
   output logic [3:0] sltsl_n,
   output logic [3:0] slt3_n,
   output logic       slot3_sel,
   output logic [7:0] sub_rdata
);

   logic [1:0] page;
   logic [1:0] prim;
   logic [1:0] sub_sel;
   logic [7:0] sub_reg;
   logic       mem_cyc;

   assign page = addr[15:14];

   assign cs0_n  = (page != 2'b00);
   assign cs1_n  = (page != 2'b01);
   assign cs2_n  = (page != 2'b10);
   assign cs01_n = cs0_n & cs1_n;
   assign cs12_n = cs1_n & cs2_n;

   // Two bits of addr_map per page
   always_comb begin
      prim = 2'b00;
      if (map_valid) begin
         case (page)
            2'b00:   prim = addr_map[1:0];
            2'b01:   prim = addr_map[3:2];
            2'b10:   prim = addr_map[5:4];
            default: prim = addr_map[7:6];
         endcase
      end
   end

   assign mem_cyc   = ~mreq_n & rfrsh_n;
   assign sltsl_n   = mem_cyc ? ~(4'b0001 << prim) : 4'hF;
   assign slot3_sel = ~sltsl_n[3];

   always_ff @(posedge reset or posedge clk21m) begin
      if (clk21m) begin
         sub_reg <= 8'h00;
      end else if (sub_wr) begin
         sub_reg <= d_from_cpu;
      end
   end

   always_comb begin
      case (page)
         2'b00:   sub_sel = sub_reg[1:0];
         2'b01:   sub_sel = sub_reg[3:2];
         2'b10:   sub_sel = sub_reg[5:4];
         default: sub_sel = sub_reg[7:6];
      endcase
   end

   assign slt3_n = slot3_sel ? ~(4'b0001 << sub_sel) : 4'hF;

   // MSX reads the subslot register back inverted
   assign sub_rdata = ~sub_reg;

endmodule

`default_nettype wire

// ==== verilog/msx_io_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx_io_decode (
   input  wire        reset,
   input  wire        clk21m,
   input  wire [15:0] addr,
   input  wire        wr_n,
   input  wire        rd_n,
   input  wire        iorq_n,
   input  wire        mreq_n,
   input  wire        m1_n,
   input  wire        slot3_sel,
   input  wire  [7:0] rtc_rdata,
   input  wire  [7:0] mpr_rdata,
   input  wire  [7:0] sub_rdata,
   output logic       rtc_wr,
   output logic       mpr_wr,
   output logic       sub_wr,
   output logic [7:0] d_to_cpu,
   output logic       data_bus_rq
);
   import msx_io_pkg::*;

   logic io_cyc;
   logic rtc_en;
   logic mpr_en;
   logic sub_en;
   logic ack;
   logic req;

   // Interrupt acknowledge also pulls iorq_n, so m1_n must be high
   assign io_cyc = ~iorq_n & m1_n;
   assign rtc_en = io_cyc & (addr[7:1] == PORT_RTC_BASE[7:1]);
   assign mpr_en = io_cyc & (addr[7:2] == PORT_MPR_BASE[7:2]);
   assign sub_en = ~mreq_n & slot3_sel & (addr == SUBSLOT_ADDR);

   // Open request until the first clock of the bus cycle
   assign req = ~((iorq_n & mreq_n) | (wr_n & rd_n) | ack);

   always_ff @(posedge reset or posedge clk21m) begin
      if (clk21m) begin
         ack <= 1'b0;
      end else if (iorq_n & mreq_n) begin
         ack <= 1'b0;
      end else if (req) begin
         ack <= 1'b1;
      end
   end

   assign rtc_wr = req & ~wr_n & rtc_en;
   assign mpr_wr = req & ~wr_n & mpr_en;
   assign sub_wr = req & ~wr_n & sub_en;

   always_comb begin
      d_to_cpu = 8'hFF;
      if (!rd_n) begin
         if (rtc_en) begin
            d_to_cpu = rtc_rdata;
         end else if (mpr_en) begin
            d_to_cpu = mpr_rdata;
         end else if (sub_en) begin
            d_to_cpu = sub_rdata;
         end
      end
   end

   // Unclaimed reads leave the bus to pull-ups
   assign data_bus_rq = ~rd_n & (rtc_en | mpr_en | sub_en);

endmodule

`default_nettype wire

// ==== common/msx_io_pkg.sv ====
`default_nettype none

package msx_io_pkg;

   // I/O ports and the subslot register location
   localparam logic [7:0]  PORT_RTC_BASE = 8'hB4;
   localparam logic [7:0]  PORT_MPR_BASE = 8'hFC;
   localparam logic [15:0] SUBSLOT_ADDR  = 16'hFFFF;

   // ce_10hz pulses in one second
   localparam int unsigned RTC_TICKS_PER_SEC = 10;

   // Clock chip register index with plain storage at 6 to 12
   typedef enum logic [3:0] {
      reg_sec_lo  = 4'd0,
      reg_sec_hi  = 4'd1,
      reg_min_lo  = 4'd2,
      reg_min_hi  = 4'd3,
      reg_hour_lo = 4'd4,
      reg_hour_hi = 4'd5,
      reg_mode    = 4'd13,
      reg_test    = 4'd14,
      reg_reset   = 4'd15
   } rtc_reg_t;

endpackage

`default_nettype wire

// ==== common/msx_cfg_pkg.sv ====
`default_nettype none

package msx_cfg_pkg;

   // Installed RAM size
   typedef enum logic [1:0] {
      size64  = 2'd0,
      size128 = 2'd1,
      size256 = 2'd2,
      size512 = 2'd3
   } ram_size_t;

   // Segment bits above the installed RAM
   localparam logic [7:0] MAPPER_MASK_64  = 8'hFC;
   localparam logic [7:0] MAPPER_MASK_128 = 8'hF8;
   localparam logic [7:0] MAPPER_MASK_256 = 8'hF0;
   localparam logic [7:0] MAPPER_MASK_512 = 8'hE0;

   // Segments after reset for pages 0 to 3
   localparam logic [7:0] MAPPER_RESET_SEG [0:3] = '{
      8'd3,
      8'd2,
      8'd1,
      8'd0
   };

endpackage

`default_nettype wire
